// ==== cache_tags.f ====
rtl/cache_cfg_pkg.sv
rtl/cache_req_pkg.sv
rtl/req_decode.sv
rtl/tag_way_mem.sv
rtl/lru_nway.sv
rtl/tag_mem_nway.sv
rtl/cache_tag_top.sv
test/tb_cache_tags.sv

// ==== rtl/cache_cfg_pkg.sv ====
// ------------------------------
// cache geometry shared by all blocks
// line size and flag layout are fixed here, way count and set count
// are module parameters
// ------------------------------
`default_nettype none

package cache_cfg_pkg;

    localparam int ABUS       = 32;              // address width
    localparam int LNBITS     = 4;               // log2 of bytes per line
    localparam int LINE_BYTES = 1 << LNBITS;     // 16 bytes per line
    localparam int LINE_BITS  = 8 * LINE_BYTES;  // 128-bit line
    localparam int FLBITS     = 4;               // flags kept with each tag

    // flag bit positions
    localparam int FL_VALID = 0;
    localparam int FL_DIRTY = 1;

    // defaults handed down by the top level
    localparam int DEF_WAYBITS = 2;  // 4 ways
    localparam int DEF_IBITS   = 6;  // 64 sets

endpackage

`default_nettype wire

// ==== rtl/cache_req_pkg.sv ====
// ------------------------------
// request and response types of the cache lookup port
// one request per cycle, the response follows one cycle later
// ------------------------------
`default_nettype none

package cache_req_pkg;

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,
        OP_READ   = 3'd1,  // lookup by tag
        OP_WRITE  = 3'd2,  // fill or update of the line looked up last cycle
        OP_INVAL  = 3'd3,  // clear flags of a hitting line
        OP_DIRECT = 3'd4   // read the way named by addr low bits
    } cache_op_e;

    typedef struct packed {
        cache_op_e                             op;
        logic [cache_cfg_pkg::ABUS-1:0]        addr;
        logic [cache_cfg_pkg::LINE_BITS-1:0]   wdata;
        logic [cache_cfg_pkg::LINE_BYTES-1:0]  wstrb;
        logic [cache_cfg_pkg::FLBITS-1:0]      wflags;
    } cache_req_t;

    typedef struct packed {
        logic                                  hit;
        logic [cache_cfg_pkg::ABUS-1:0]        raddr;   // stored tag as a line address
        logic [cache_cfg_pkg::LINE_BITS-1:0]   rdata;
        logic [cache_cfg_pkg::FLBITS-1:0]      rflags;
    } cache_resp_t;

endpackage

`default_nettype wire

// ==== rtl/cache_tag_top.sv ====
// ------------------------------
// cache lookup core top level
// no handshake, one request per cycle
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_tag_top #(
    parameter int waybits = cache_cfg_pkg::DEF_WAYBITS,
    parameter int ibits   = cache_cfg_pkg::DEF_IBITS
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  cache_req_pkg::cache_req_t   i_req,
    output cache_req_pkg::cache_resp_t  o_resp
);
    import cache_cfg_pkg::*;

    logic                  re;
    logic                  we;
    logic                  inval;
    logic                  direct;
    logic [ABUS-1:0]       addr;
    logic [LINE_BITS-1:0]  wdata;
    logic [LINE_BYTES-1:0] wstrb;
    logic [FLBITS-1:0]     wflags;

    req_decode u_dec (
        .i_req    (i_req),
        .o_re     (re),
        .o_we     (we),
        .o_inval  (inval),
        .o_direct (direct),
        .o_addr   (addr),
        .o_wdata  (wdata),
        .o_wstrb  (wstrb),
        .o_wflags (wflags)
    );

    tag_mem_nway #(
        .waybits (waybits),
        .ibits   (ibits)
    ) u_store (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_re     (re),
        .i_we     (we),
        .i_inval  (inval),
        .i_direct (direct),
        .i_addr   (addr),
        .i_wdata  (wdata),
        .i_wstrb  (wstrb),
        .i_wflags (wflags),
        .o_resp   (o_resp)
    );

endmodule

`default_nettype wire

// ==== rtl/lru_nway.sv ====
// ------------------------------
// per-set LRU order of way indices
// entry 0 is least recent, entry N-1 most recent
// init takes priority over up, up over down
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module lru_nway #(
    parameter int ibits   = 6,
    parameter int waybits = 2
) (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_init,
    input  logic [ibits-1:0]   i_raddr,
    input  logic [ibits-1:0]   i_waddr,
    input  logic               i_up,
    input  logic               i_down,
    input  logic [waybits-1:0] i_lru,
    output logic [waybits-1:0] o_lru
);

    localparam int NWAYS = 2 ** waybits;
    localparam int NSETS = 2 ** ibits;

    logic [NWAYS-1:0][waybits-1:0] order_q [NSETS];
    logic [NWAYS-1:0][waybits-1:0] cur;
    logic [NWAYS-1:0][waybits-1:0] nxt;
    logic [ibits-1:0]              r_raddr;
    logic                          upd;

    assign upd = i_init | i_up | i_down;
    assign cur = order_q[i_waddr];

    always_comb begin
        int pos;
        pos = 0;
        for (int k = 0; k < NWAYS; k++) begin
            if (cur[k] == i_lru) begin
                pos = k;  // current slot of the way being moved
            end
        end
        nxt = cur;
        if (i_init) begin
            for (int k = 0; k < NWAYS; k++) begin
                nxt[k] = waybits'(k);
            end
        end else if (i_up) begin
            for (int k = 0; k < NWAYS - 1; k++) begin
                if (k >= pos) begin
                    nxt[k] = cur[k+1];
                end
            end
            nxt[NWAYS-1] = i_lru;
        end else if (i_down) begin
            for (int k = 1; k < NWAYS; k++) begin
                if (k <= pos) begin
                    nxt[k] = cur[k-1];
                end
            end
            nxt[0] = i_lru;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_raddr <= '0;
            for (int s = 0; s < NSETS; s++) begin
                for (int k = 0; k < NWAYS; k++) begin
                    order_q[s][k] <= waybits'(k);
                end
            end
        end else begin
            r_raddr <= i_raddr;
            if (upd) begin
                order_q[i_waddr] <= nxt;
            end
        end
    end

    assign o_lru = order_q[r_raddr][0];

endmodule

`default_nettype wire

// ==== rtl/req_decode.sv ====
// ------------------------------
// op decoder, purely combinational
// byte strobes pass only with a write op
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module req_decode (
    input  cache_req_pkg::cache_req_t              i_req,
    output logic                                   o_re,
    output logic                                   o_we,
    output logic                                   o_inval,
    output logic                                   o_direct,
    output logic [cache_cfg_pkg::ABUS-1:0]         o_addr,
    output logic [cache_cfg_pkg::LINE_BITS-1:0]    o_wdata,
    output logic [cache_cfg_pkg::LINE_BYTES-1:0]   o_wstrb,
    output logic [cache_cfg_pkg::FLBITS-1:0]       o_wflags
);
    import cache_req_pkg::*;

    always_comb begin
        o_re     = 1'b0;
        o_we     = 1'b0;
        o_inval  = 1'b0;
        o_direct = 1'b0;
        case (i_req.op)
            OP_READ:  o_re = 1'b1;
            OP_WRITE: o_we = 1'b1;
            OP_INVAL: o_inval = 1'b1;
            OP_DIRECT: begin
                o_re     = 1'b1;  // direct access is a read too
                o_direct = 1'b1;
            end
            default: ;            // OP_NONE and unused codes idle
        endcase
    end

    assign o_addr   = i_req.addr;
    assign o_wdata  = i_req.wdata;
    assign o_wstrb  = o_we ? i_req.wstrb : '0;
    assign o_wflags = i_req.wflags;

endmodule

`default_nettype wire

// ==== rtl/tag_mem_nway.sv ====
// ------------------------------
// N-way tag and line store with LRU victim choice
// a write or invalidate lands in the way chosen for the previous
// request, so its address must equal the looked-up address
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tag_mem_nway #(
    parameter int waybits = 2,
    parameter int ibits   = 6
) (
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic                                   i_re,
    input  logic                                   i_we,
    input  logic                                   i_inval,
    input  logic                                   i_direct,
    input  logic [cache_cfg_pkg::ABUS-1:0]         i_addr,
    input  logic [cache_cfg_pkg::LINE_BITS-1:0]    i_wdata,
    input  logic [cache_cfg_pkg::LINE_BYTES-1:0]   i_wstrb,
    input  logic [cache_cfg_pkg::FLBITS-1:0]       i_wflags,
    output cache_req_pkg::cache_resp_t             o_resp
);
    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    localparam int NWAYS = 2 ** waybits;

    typedef struct packed {
        logic [ABUS-1:0] addr;
        logic            direct;
        logic            inval;
        logic            re;
    } req_reg_t;

    req_reg_t              r_q;
    cache_resp_t           way_o     [NWAYS];
    logic [LINE_BYTES-1:0] way_wstrb [NWAYS];
    logic [waybits-1:0]    sel;
    logic [waybits-1:0]    lru_way;
    logic                  sel_hit;
    logic                  way_we;
    logic [LINE_BYTES-1:0] wstrb_sel;
    logic [FLBITS-1:0]     wflags_sel;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_q <= '0;
        end else begin
            r_q.addr   <= i_addr;
            r_q.direct <= i_direct;
            r_q.inval  <= i_inval;
            r_q.re     <= i_re;
        end
    end

    for (genvar w = 0; w < NWAYS; w++) begin : g_way
        tag_way_mem #(
            .ibits(ibits)
        ) u_way (
            .i_clk    (i_clk),
            .i_nrst   (i_nrst),
            .i_addr   (i_addr),
            .i_wdata  (i_wdata),
            .i_wstrb  (way_wstrb[w]),
            .i_wflags (wflags_sel),
            .o_raddr  (way_o[w].raddr),
            .o_rdata  (way_o[w].rdata),
            .o_rflags (way_o[w].rflags),
            .o_hit    (way_o[w].hit)
        );
    end

    // direct index first, then highest hitting way, else the victim
    always_comb begin
        sel = lru_way;
        if (r_q.direct) begin
            sel = r_q.addr[waybits-1:0];
        end else begin
            for (int w = 0; w < NWAYS; w++) begin
                if (way_o[w].hit) begin
                    sel = waybits'(w);
                end
            end
        end
    end

    assign sel_hit = way_o[sel].hit;
    assign o_resp  = way_o[sel];

    // invalidate rewrites the whole line entry with cleared flags
    assign way_we     = i_we | (r_q.inval & sel_hit);
    assign wstrb_sel  = r_q.inval ? '1 : i_wstrb;
    assign wflags_sel = r_q.inval ? '0 : i_wflags;

    always_comb begin
        for (int w = 0; w < NWAYS; w++) begin
            way_wstrb[w] = (way_we && (sel == waybits'(w))) ? wstrb_sel : '0;
        end
    end

    lru_nway #(
        .ibits   (ibits),
        .waybits (waybits)
    ) u_lru (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_init  (r_q.direct),
        .i_raddr (i_addr[LNBITS +: ibits]),
        .i_waddr (r_q.addr[LNBITS +: ibits]),
        .i_up    (i_we | (sel_hit & r_q.re)),  // fill or read hit becomes most recent
        .i_down  (sel_hit & r_q.inval),
        .i_lru   (sel),
        .o_lru   (lru_way)
    );

endmodule

`default_nettype wire

// ==== rtl/tag_way_mem.sv ====
// ------------------------------
// one cache way: tag, flags and line per set
// write goes to the set of the address presented in the same cycle
// read data appears the cycle after the address
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tag_way_mem #(
    parameter int ibits = 6
) (
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic [cache_cfg_pkg::ABUS-1:0]         i_addr,
    input  logic [cache_cfg_pkg::LINE_BITS-1:0]    i_wdata,
    input  logic [cache_cfg_pkg::LINE_BYTES-1:0]   i_wstrb,
    input  logic [cache_cfg_pkg::FLBITS-1:0]       i_wflags,
    output logic [cache_cfg_pkg::ABUS-1:0]         o_raddr,
    output logic [cache_cfg_pkg::LINE_BITS-1:0]    o_rdata,
    output logic [cache_cfg_pkg::FLBITS-1:0]       o_rflags,
    output logic                                   o_hit
);
    import cache_cfg_pkg::*;

    localparam int NSETS   = 2 ** ibits;
    localparam int TAGBITS = ABUS - ibits - LNBITS;

    logic [TAGBITS-1:0]   tag_mem  [NSETS];
    logic [LINE_BITS-1:0] line_mem [NSETS];
    logic [FLBITS-1:0]    flag_mem [NSETS];  // valid and dirty bits per set

    logic [ibits-1:0]   idx;
    logic [TAGBITS-1:0] tag;
    logic [ibits-1:0]   r_idx;
    logic [TAGBITS-1:0] r_tag;
    logic               wr_en;

    assign idx   = i_addr[LNBITS +: ibits];
    assign tag   = i_addr[ABUS-1 -: TAGBITS];
    assign wr_en = |i_wstrb;

    // lookup address, used one cycle later
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_idx <= '0;
        end else begin
            r_idx <= idx;
        end
    end

    always_ff @(posedge i_clk) begin
        r_tag <= tag;
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            tag_mem[idx] <= tag;
        end
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_wstrb[b]) begin
                line_mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int s = 0; s < NSETS; s++) begin
                flag_mem[s] <= '0;
            end
        end else if (wr_en) begin
            flag_mem[idx] <= i_wflags;
        end
    end

    // stored tag rebuilt into a line address
    assign o_raddr  = {tag_mem[r_idx], r_idx, {LNBITS{1'b0}}};
    assign o_rdata  = line_mem[r_idx];
    assign o_rflags = flag_mem[r_idx];
    assign o_hit    = (tag_mem[r_idx] == r_tag) && flag_mem[r_idx][FL_VALID];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cache tag testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cache_tags \
    -f cache_tags.f -o sim_tb_cache_tags
./obj_dir/sim_tb_cache_tags | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== test/tb_cache_tags.sv ====
// ------------------------------
// testbench for cache_tag_top with 4 ways and 64 sets
// a write or invalidate follow-up repeats the looked-up address
// responses are checked half a cycle into the cycle after the request
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cache_tags;
    import cache_cfg_pkg::*;
    import cache_req_pkg::*;

    localparam int WAYBITS    = 2;
    localparam int IBITS      = 6;
    localparam int NWAYS      = 1 << WAYBITS;
    localparam int NSETS      = 1 << IBITS;
    localparam int TAGBITS    = ABUS - IBITS - LNBITS;
    localparam int MAX_CYCLES = 2000;  // far above the roughly 60 cycles all tests take

    localparam logic [FLBITS-1:0] F_VALID = FLBITS'(1 << FL_VALID);
    localparam logic [FLBITS-1:0] F_DIRTY = FLBITS'(1 << FL_DIRTY);

    typedef struct packed {
        logic                 chk_hit;
        logic                 chk_line;  // raddr, rdata and rflags are known
        logic                 hit;
        logic [ABUS-1:0]      raddr;
        logic [LINE_BITS-1:0] rdata;
        logic [FLBITS-1:0]    rflags;
    } expect_t;

    typedef struct packed {
        cache_op_e          op;
        logic [ABUS-1:0]    addr;
        logic [WAYBITS-1:0] sel;
        logic               hit;
    } lookup_t;

    logic        clk;
    logic        nrst;
    cache_req_t  req;
    cache_resp_t resp;
    expect_t     exp_cur;  // expectation of the request being driven
    expect_t     exp_q;    // expectation of the response on o_resp
    lookup_t     pend;     // model's lookup of the previous request
    integer      seed;
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;
    int          test_fail;
    int          err_start;
    int          cyc;

    // reference model of the store
    logic [TAGBITS-1:0]   m_tag   [NSETS][NWAYS];
    logic [LINE_BITS-1:0] m_data  [NSETS][NWAYS];
    logic [FLBITS-1:0]    m_flags [NSETS][NWAYS];
    logic                 m_used  [NSETS][NWAYS];
    int                   m_order [NSETS][NWAYS];  // entry 0 least recent

    cache_tag_top #(
        .waybits (WAYBITS),
        .ibits   (IBITS)
    ) i_dut (
        .i_clk  (clk),
        .i_nrst (nrst),
        .i_req  (req),
        .o_resp (resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            exp_q <= '0;
        end else begin
            exp_q <= exp_cur;
        end
    end

    // o_resp and exp_q only move on the rising edge
    a_hit: assert property (@(negedge clk) disable iff (!nrst)
        exp_q.chk_hit |-> (resp.hit == exp_q.hit))
        else begin
            $display("Mismatch o_resp.hit: got %h, expected %h", resp.hit, exp_q.hit);
            err_cnt++;
        end

    a_raddr: assert property (@(negedge clk) disable iff (!nrst)
        exp_q.chk_line |-> (resp.raddr == exp_q.raddr))
        else begin
            $display("Mismatch o_resp.raddr: got %h, expected %h", resp.raddr, exp_q.raddr);
            err_cnt++;
        end

    a_rdata: assert property (@(negedge clk) disable iff (!nrst)
        exp_q.chk_line |-> (resp.rdata == exp_q.rdata))
        else begin
            $display("Mismatch o_resp.rdata: got %h, expected %h", resp.rdata, exp_q.rdata);
            err_cnt++;
        end

    a_rflags: assert property (@(negedge clk) disable iff (!nrst)
        exp_q.chk_line |-> (resp.rflags == exp_q.rflags))
        else begin
            $display("Mismatch o_resp.rflags: got %h, expected %h", resp.rflags, exp_q.rflags);
            err_cnt++;
        end

    function automatic int set_of(input logic [ABUS-1:0] a);
        return int'(a[LNBITS +: IBITS]);
    endfunction

    function automatic logic [TAGBITS-1:0] tag_of(input logic [ABUS-1:0] a);
        return a[ABUS-1 -: TAGBITS];
    endfunction

    function automatic logic [ABUS-1:0] mk_addr(input logic [TAGBITS-1:0] t, input int s,
                                                 input int low);
        return {t, IBITS'(s), LNBITS'(low)};
    endfunction

    function automatic logic [LINE_BITS-1:0] rand_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // low bits carry i so tags made with different i never collide
    function automatic logic [TAGBITS-1:0] rand_tag(input int i);
        logic [TAGBITS-1:0] t;
        t = TAGBITS'($random(seed));
        return {t[TAGBITS-1:3], 3'(i)};
    endfunction

    function automatic int way_of(input int s, input logic [TAGBITS-1:0] t);
        int w;
        w = -1;
        for (int k = 0; k < NWAYS; k++) begin
            if (m_flags[s][k][FL_VALID] && m_tag[s][k] == t) begin
                w = k;
            end
        end
        return w;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < NSETS; s++) begin
            for (int w = 0; w < NWAYS; w++) begin
                m_tag[s][w]   = '0;
                m_data[s][w]  = '0;
                m_flags[s][w] = '0;
                m_used[s][w]  = 1'b0;
                m_order[s][w] = w;
            end
        end
        pend = '0;
    endtask

    task automatic move_way(input int s, input int w, input bit to_mru);
        int rest [$];
        for (int k = 0; k < NWAYS; k++) begin
            if (m_order[s][k] != w) begin
                rest.push_back(m_order[s][k]);
            end
        end
        if (to_mru) begin
            rest.push_back(w);
        end else begin
            rest.push_front(w);
        end
        for (int k = 0; k < NWAYS; k++) begin
            m_order[s][k] = rest[k];
        end
    endtask

    // what happens at the end of the cycle in which r is driven
    task automatic apply_cycle(input cache_req_t r);
        int                    ps;
        int                    s;
        int                    w;
        logic [LINE_BYTES-1:0] strb;
        ps   = set_of(pend.addr);
        s    = set_of(r.addr);
        w    = int'(pend.sel);
        strb = '0;
        if (r.op == OP_WRITE || (pend.op == OP_INVAL && pend.hit)) begin
            strb = (pend.op == OP_INVAL) ? '1 : r.wstrb;
        end
        if (|strb) begin
            m_tag[s][w]   = tag_of(r.addr);
            m_flags[s][w] = (pend.op == OP_INVAL) ? '0 : r.wflags;
            m_used[s][w]  = 1'b1;
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (strb[b]) begin
                    m_data[s][w][8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
        end
        if (pend.op == OP_DIRECT) begin
            for (int k = 0; k < NWAYS; k++) begin
                m_order[ps][k] = k;
            end
        end else if (r.op == OP_WRITE || (pend.hit && pend.op == OP_READ)) begin
            move_way(ps, w, 1'b1);
        end else if (pend.hit && pend.op == OP_INVAL) begin
            move_way(ps, w, 1'b0);
        end
    endtask

    task automatic look_up(input cache_req_t r, input bit check);
        int                 s;
        int                 w;
        logic [TAGBITS-1:0] t;
        s = set_of(r.addr);
        t = tag_of(r.addr);
        w = m_order[s][0];  // victim unless something hits
        if (r.op == OP_DIRECT) begin
            w = int'(r.addr[WAYBITS-1:0]);
        end else begin
            for (int k = 0; k < NWAYS; k++) begin
                if (m_flags[s][k][FL_VALID] && m_tag[s][k] == t) begin
                    w = k;
                end
            end
        end
        pend.op           = r.op;
        pend.addr         = r.addr;
        pend.sel          = WAYBITS'(w);
        pend.hit          = m_flags[s][w][FL_VALID] && (m_tag[s][w] == t);
        exp_cur.chk_hit   = check;
        exp_cur.chk_line  = check && m_used[s][w];
        exp_cur.hit       = pend.hit;
        exp_cur.raddr     = {m_tag[s][w], IBITS'(s), {LNBITS{1'b0}}};
        exp_cur.rdata     = m_data[s][w];
        exp_cur.rflags    = m_flags[s][w];
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_req(input cache_op_e op, input logic [ABUS-1:0] addr,
                            input logic [LINE_BITS-1:0] wdata,
                            input logic [LINE_BYTES-1:0] wstrb,
                            input logic [FLBITS-1:0] wflags, input bit check);
        cache_req_t r;
        r.op     = op;
        r.addr   = addr;
        r.wdata  = wdata;
        r.wstrb  = wstrb;
        r.wflags = wflags;
        apply_cycle(r);
        look_up(r, check);
        if (check) begin
            chk_cnt++;
        end
        req = r;
        @(negedge clk);
    endtask

    task automatic idle_cycle();
        send_req(OP_NONE, '0, '0, '0, '0, 1'b0);
    endtask

    task automatic read_line(input logic [ABUS-1:0] addr);
        send_req(OP_READ, addr, '0, '0, '0, 1'b1);
    endtask

    task automatic read_direct(input logic [ABUS-1:0] addr);
        send_req(OP_DIRECT, addr, '0, '0, '0, 1'b1);
    endtask

    task automatic write_line(input logic [ABUS-1:0] addr, input logic [LINE_BITS-1:0] data,
                              input logic [LINE_BYTES-1:0] strb, input logic [FLBITS-1:0] fl);
        send_req(OP_WRITE, addr, data, strb, fl, 1'b1);
    endtask

    task automatic fill_line(input logic [ABUS-1:0] addr, input logic [LINE_BITS-1:0] data);
        read_line(addr);
        write_line(addr, data, '1, F_VALID);
    endtask

    // the cycle after the invalidate must carry the same address
    task automatic invalidate_line(input logic [ABUS-1:0] addr);
        send_req(OP_INVAL, addr, '0, '0, '0, 1'b1);
        send_req(OP_NONE, addr, '0, '0, '0, 1'b0);
    endtask

    task automatic start_test();
        err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        idle_cycle();  // lets the last response be checked
        idle_cycle();
        test_cnt++;
        if (err_cnt == err_start) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_start);
        end
    endtask

    initial begin
        cyc = 0;
        while (cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [TAGBITS-1:0] set5_tags [NWAYS];
        logic [TAGBITS-1:0] set9_tags [5];
        logic [TAGBITS-1:0] victim;
        int                 w;
        seed      = 32'hb9b9;
        nrst      = 1'b0;
        req       = '0;
        exp_cur   = '0;
        err_cnt   = 0;
        chk_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        err_start = 0;
        model_reset();
        repeat (2) @(negedge clk);
        nrst = 1'b1;
        idle_cycle();

        start_test();
        for (int i = 0; i < 4; i++) begin
            read_line(mk_addr(rand_tag(i), 3 + 7 * i, 0));
        end
        end_test("reads miss after reset");

        start_test();
        for (int i = 0; i < NWAYS; i++) begin
            set5_tags[i] = rand_tag(i);
            fill_line(mk_addr(set5_tags[i], 5, 0), rand_line());
        end
        for (int i = 0; i < NWAYS; i++) begin
            read_line(mk_addr(set5_tags[i], 5, 0));
        end
        end_test("fill four ways of one set");

        start_test();
        read_line(mk_addr(set5_tags[2], 5, 0));
        write_line(mk_addr(set5_tags[2], 5, 0), rand_line(), 16'h0ff0, F_VALID | F_DIRTY);
        read_line(mk_addr(set5_tags[2], 5, 0));
        end_test("partial write merges bytes");

        start_test();
        for (int i = 0; i < 5; i++) begin
            set9_tags[i] = rand_tag(i);
        end
        for (int i = 0; i < NWAYS; i++) begin
            fill_line(mk_addr(set9_tags[i], 9, 0), rand_line());
        end
        read_line(mk_addr(set9_tags[0], 9, 0));  // reorder before the eviction
        read_line(mk_addr(set9_tags[2], 9, 0));
        idle_cycle();
        victim = m_tag[9][m_order[9][0]];
        fill_line(mk_addr(set9_tags[4], 9, 0), rand_line());
        read_line(mk_addr(victim, 9, 0));
        end_test("fifth tag evicts least recent way");

        start_test();
        w = way_of(9, set9_tags[4]);
        invalidate_line(mk_addr(set9_tags[4], 9, 0));
        read_line(mk_addr(set9_tags[4], 9, 0));
        read_direct(mk_addr(set9_tags[4], 9, w));
        end_test("invalidate clears the line");

        start_test();
        for (int i = 0; i < NWAYS; i++) begin
            read_direct(mk_addr(rand_tag(7), 5, i));  // tag matches no way
        end
        read_direct(mk_addr(set5_tags[1], 5, way_of(5, set5_tags[1])));
        end_test("direct access by way index");

        $display("tests: %0d run, %0d failed, checks: %0d, errors: %0d",
                 test_cnt, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
